// ==== verilog.f ====
verilog/arp_pkg.sv
verilog/eth_hdr_rx.sv
verilog/arp_eth_rx.sv
verilog/arp_req_check.sv
verilog/arp_rx_top.sv
bench/tb_clock.sv
bench/arp_rx_properties.sv
bench/arp_rx_tb.sv

// ==== Bender.yml ====
package:
  name: arp_rx

sources:
  - files:
      - verilog/arp_pkg.sv
      - verilog/eth_hdr_rx.sv
      - verilog/arp_eth_rx.sv
      - verilog/arp_req_check.sv
      - verilog/arp_rx_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/arp_rx_properties.sv
      - bench/arp_rx_tb.sv

// ==== bench/arp_rx_tb.sv ====
//**********************************************************************
// ARP receive path testbench
// frame builder, directed tests, compare tasks, LCG random source
// and watchdog
//**********************************************************************

`timescale 1ns/1ns

module arp_rx_tb;

    logic        clk;
    logic        rst;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    logic [31:0] local_ip;
    logic        m_valid;
    logic        m_ready;
    logic [15:0] m_oper;
    logic [47:0] m_eth_src_mac;
    logic [47:0] m_sha;
    logic [31:0] m_spa;
    logic [47:0] m_tha;
    logic        busy;
    logic        error_header_early_termination;
    logic [arp_pkg::drop_count_width-1:0] drop_count;

    // fields of the frame being built
    logic [47:0] f_dest;
    logic [47:0] f_src;
    logic [15:0] f_type;
    logic [15:0] f_htype;
    logic [15:0] f_ptype;
    logic [7:0]  f_hlen;
    logic [7:0]  f_plen;
    logic [15:0] f_oper;
    logic [47:0] f_sha;
    logic [31:0] f_spa;
    logic [47:0] f_tha;
    logic [31:0] f_tpa;

    logic [7:0]   frame_bytes[$];
    // records of {oper, eth src mac, sha, spa, tha}
    logic [191:0] out_q[$];
    logic [191:0] want_q[$];

    logic [31:0] lcg_state;
    logic [arp_pkg::drop_count_width-1:0] exp_drops;
    logic        error_seen;
    logic        busy_seen;
    logic        third_done;
    int          frames_planned = 12;
    int          cycles_per_frame = 200;

    tb_clock clock0 (
        .clk(clk)
    );

    arp_rx_top dut0 (
        .clk(clk),
        .rst(rst),
        .s_tdata(s_tdata),
        .s_tvalid(s_tvalid),
        .s_tready(s_tready),
        .s_tlast(s_tlast),
        .local_ip(local_ip),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .m_oper(m_oper),
        .m_eth_src_mac(m_eth_src_mac),
        .m_sha(m_sha),
        .m_spa(m_spa),
        .m_tha(m_tha),
        .busy(busy),
        .error_header_early_termination(error_header_early_termination),
        .drop_count(drop_count)
    );

    // output handshakes and error pulses, seen at the clock edge
    always @(posedge clk) begin
        if (m_valid && m_ready) begin
            out_q.push_back({m_oper, m_eth_src_mac, m_sha, m_spa, m_tha});
        end
        if (error_header_early_termination) begin
            error_seen = 1'b1;
        end
        if (busy) begin
            busy_seen = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (dut0.props0.assert_failures != 0) begin
            $display("a handshake assertion failed at %0t ns", $time);
            stop_run();
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("FAIL at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic default_frame();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        r0 = next_random();
        r1 = next_random();
        r2 = next_random();
        r3 = next_random();
        r4 = next_random();
        r5 = next_random();
        f_dest = 48'hffff_ffff_ffff;
        // locally administered sender
        f_src = {8'h02, r0[7:0], r1};
        f_type = arp_pkg::ethertype_arp;
        f_htype = arp_pkg::arp_htype_eth;
        f_ptype = arp_pkg::arp_ptype_ipv4;
        f_hlen = arp_pkg::arp_hlen_eth;
        f_plen = arp_pkg::arp_plen_ipv4;
        f_oper = arp_pkg::arp_oper_request;
        f_sha = {8'h02, r4[7:0], r5};
        f_spa = {8'd10, r2[23:0]};
        f_tha = {r3, r2[31:16]};
        f_tpa = local_ip;
    endtask

    task automatic push_bytes(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            frame_bytes.push_back(value[8*i +: 8]);
        end
    endtask

    // header and ARP body go out most significant byte first
    task automatic build_frame(input int pad_len);
        frame_bytes.delete();
        push_bytes(f_dest, 6);
        push_bytes(f_src, 6);
        push_bytes(f_type, 2);
        push_bytes(f_htype, 2);
        push_bytes(f_ptype, 2);
        push_bytes(f_hlen, 1);
        push_bytes(f_plen, 1);
        push_bytes(f_oper, 2);
        push_bytes(f_sha, 6);
        push_bytes(f_spa, 4);
        push_bytes(f_tha, 6);
        push_bytes(f_tpa, 4);
        for (int i = 0; i < pad_len; i++) begin
            frame_bytes.push_back(8'h00);
        end
    endtask

    task automatic expect_output();
        want_q.push_back({f_oper, f_src, f_sha, f_spa, f_tha});
    endtask

    // one byte per handshake, with random idle cycles between bytes
    task automatic send_frame();
        logic [31:0] r;
        int n;
        n = frame_bytes.size();
        for (int i = 0; i < n; i++) begin
            r = next_random();
            if (r[31:30] == 2'b00) begin
                s_tvalid = 1'b0;
                @(negedge clk);
            end
            s_tdata = frame_bytes[i];
            s_tlast = (i == n - 1);
            s_tvalid = 1'b1;
            while (!s_tready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    // arp_valid follows the last body byte and the checker takes one more cycle
    task automatic wait_frame_done();
        int n;
        n = 0;
        while (busy && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            report_timeout("busy stayed high after the frame ended");
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_for_output();
        int n;
        n = 0;
        while (out_q.size() == 0 && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (out_q.size() == 0) begin
            report_timeout("no output frame arrived");
        end
    endtask

    task automatic check_frame(input logic [15:0] oper, input logic [47:0] src_mac,
                               input logic [47:0] sha, input logic [31:0] spa,
                               input logic [47:0] tha);
        logic [191:0] got;
        wait_for_output();
        got = out_q.pop_front();
        if (got[191:176] !== oper) begin
            report_failure($sformatf("m_oper %h, expected %h", got[191:176], oper));
        end
        if (got[175:128] !== src_mac) begin
            report_failure($sformatf("m_eth_src_mac %h, expected %h", got[175:128], src_mac));
        end
        if (got[127:80] !== sha) begin
            report_failure($sformatf("m_sha %h, expected %h", got[127:80], sha));
        end
        if (got[79:48] !== spa) begin
            report_failure($sformatf("m_spa %h, expected %h", got[79:48], spa));
        end
        if (got[47:0] !== tha) begin
            report_failure($sformatf("m_tha %h, expected %h", got[47:0], tha));
        end
    endtask

    task automatic check_expected_output();
        logic [191:0] want;
        want = want_q.pop_front();
        check_frame(want[191:176], want[175:128], want[127:80], want[79:48], want[47:0]);
    endtask

    task automatic check_no_output();
        if (out_q.size() != 0) begin
            report_failure($sformatf("%0d unexpected output frames", out_q.size()));
        end
    endtask

    task automatic check_drop_count(input logic [arp_pkg::drop_count_width-1:0] expected);
        if (drop_count !== expected) begin
            report_failure($sformatf("drop_count %0d, expected %0d", drop_count, expected));
        end
    endtask

    task automatic check_error_pulse(input logic expected);
        if (error_seen !== expected) begin
            report_failure($sformatf("early termination pulse %b, expected %b",
                                     error_seen, expected));
        end
        error_seen = 1'b0;
    endtask

    task automatic test_request();
        default_frame();
        build_frame(0);
        expect_output();
        send_frame();
        check_expected_output();
        wait_frame_done();
        check_no_output();
        check_error_pulse(1'b0);
        check_drop_count(exp_drops);
    endtask

    task automatic test_padding();
        default_frame();
        build_frame(18);
        expect_output();
        send_frame();
        wait_frame_done();
        check_expected_output();
        check_no_output();
        // unicast reply right behind the padded frame
        default_frame();
        f_dest = 48'h0200_0000_0001;
        f_oper = arp_pkg::arp_oper_reply;
        build_frame(0);
        expect_output();
        send_frame();
        check_expected_output();
        wait_frame_done();
        check_no_output();
        check_error_pulse(1'b0);
    endtask

    task automatic test_non_arp();
        default_frame();
        f_type = 16'h0800;
        build_frame(30);
        busy_seen = 1'b0;
        send_frame();
        wait_frame_done();
        if (!busy_seen) begin
            report_failure("busy stayed low while a frame was being discarded");
        end
        check_no_output();
        check_drop_count(exp_drops);
        default_frame();
        build_frame(0);
        expect_output();
        send_frame();
        check_expected_output();
        wait_frame_done();
        check_error_pulse(1'b0);
    endtask

    task automatic test_short_frame();
        default_frame();
        build_frame(0);
        // keep 20 of the body bytes
        while (frame_bytes.size() > arp_pkg::eth_hdr_len + arp_pkg::arp_body_len - 8) begin
            void'(frame_bytes.pop_back());
        end
        send_frame();
        wait_frame_done();
        check_error_pulse(1'b1);
        check_no_output();
        check_drop_count(exp_drops);
    endtask

    task automatic send_rejected_frame();
        build_frame(0);
        send_frame();
        wait_frame_done();
        exp_drops = exp_drops + 1'b1;
        check_drop_count(exp_drops);
        check_no_output();
    endtask

    task automatic test_rejects();
        default_frame();
        f_tpa = local_ip ^ 32'h0000_0001;
        send_rejected_frame();
        default_frame();
        f_htype = 16'h0006;
        send_rejected_frame();
        default_frame();
        f_oper = 16'h0003;
        send_rejected_frame();
        check_error_pulse(1'b0);
    endtask

    // two frames fill the output stage and the decoder, a third one stalls the input
    task automatic test_backpressure();
        int n;
        m_ready = 1'b0;
        default_frame();
        build_frame(0);
        expect_output();
        send_frame();
        default_frame();
        build_frame(4);
        expect_output();
        send_frame();
        default_frame();
        build_frame(0);
        expect_output();
        third_done = 1'b0;
        fork
            begin
                send_frame();
                third_done = 1'b1;
            end
        join_none
        n = 0;
        while (!(s_tvalid && !s_tready) && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (!(s_tvalid && !s_tready)) begin
            report_timeout("the input never stalled while m_ready was low");
        end
        repeat (20) @(negedge clk);
        if (s_tready !== 1'b0 || third_done) begin
            report_failure("input accepted bytes while the output stage was full");
        end
        if (m_valid !== 1'b1) begin
            report_failure("m_valid low while the first frame is held");
        end
        check_no_output();
        m_ready = 1'b1;
        check_expected_output();
        check_expected_output();
        check_expected_output();
        n = 0;
        while (!third_done && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (!third_done) begin
            report_timeout("the stalled frame was never fully accepted");
        end
        wait_frame_done();
        check_no_output();
        check_drop_count(exp_drops);
    endtask

    initial begin
        repeat (frames_planned * cycles_per_frame) @(posedge clk);
        report_timeout("the tests did not finish in time");
    end

    initial begin
        rst = 1'b1;
        s_tdata = 8'h00;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        local_ip = 32'hc0a8_0164;
        m_ready = 1'b1;
        lcg_state = 32'h70705c7f;
        exp_drops = '0;
        error_seen = 1'b0;
        busy_seen = 1'b0;
        third_done = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_drop_count(exp_drops);
        test_request();
        test_padding();
        test_non_arp();
        test_short_frame();
        test_rejects();
        test_backpressure();
        if (dut0.props0.assert_failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", dut0.props0.assert_failures);
            stop_run();
        end
    end

endmodule

// ==== bench/arp_rx_properties.sv ====
//**********************************************************************
// handshake assertions for the ARP receive path
// stalled transfers hold, quiet output after reset and a
// single-cycle early termination pulse, attached with bind
//**********************************************************************

`timescale 1ns/1ns

module arp_rx_properties (
    input logic        clk,
    input logic        rst,
    input logic [7:0]  s_tdata,
    input logic        s_tvalid,
    input logic        s_tready,
    input logic        s_tlast,
    input logic        arp_valid,
    input logic        arp_ready,
    input logic [31:0] arp_tpa,
    input logic        m_valid,
    input logic        m_ready,
    input logic [47:0] m_sha,
    input logic        error_header_early_termination
);

    int assert_failures = 0;

    s_hold: assert property (@(posedge clk) disable iff (rst)
        s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata) && $stable(s_tlast))
        else begin
            $error("input stream changed before its transfer completed");
            assert_failures++;
        end

    arp_hold: assert property (@(posedge clk) disable iff (rst)
        arp_valid && !arp_ready |=> arp_valid && $stable(arp_tpa))
        else begin
            $error("decoder output changed before the checker took it");
            assert_failures++;
        end

    m_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_sha))
        else begin
            $error("output frame changed before m_ready");
            assert_failures++;
        end

    // first edge out of reset
    m_quiet: assert property (@(posedge clk) $fell(rst) |-> !m_valid)
        else begin
            $error("m_valid high right after reset");
            assert_failures++;
        end

    err_pulse: assert property (@(posedge clk) disable iff (rst)
        error_header_early_termination |=> !error_header_early_termination)
        else begin
            $error("early termination error wider than one cycle");
            assert_failures++;
        end

endmodule

bind arp_rx_top arp_rx_properties props0 (
    .clk(clk),
    .rst(rst),
    .s_tdata(s_tdata),
    .s_tvalid(s_tvalid),
    .s_tready(s_tready),
    .s_tlast(s_tlast),
    .arp_valid(arp_valid),
    .arp_ready(arp_ready),
    .arp_tpa(arp_tpa),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_sha(m_sha),
    .error_header_early_termination(error_header_early_termination)
);

// ==== bench/tb_clock.sv ====
//**********************************************************************
// testbench clock generator, 20 ns period
//**********************************************************************

`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// ==== verilog/arp_rx_top.sv ====
//**********************************************************************
// ARP receive path
// Ethernet header receiver, ARP decoder and local IP checker in series
//**********************************************************************

`timescale 1ns/1ns

module arp_rx_top (
    input  logic        clk,
    input  logic        rst,

    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,

    input  logic [31:0] local_ip,

    output logic        m_valid,
    input  logic        m_ready,
    output logic [15:0] m_oper,
    output logic [47:0] m_eth_src_mac,
    output logic [47:0] m_sha,
    output logic [31:0] m_spa,
    output logic [47:0] m_tha,

    output logic        busy,
    output logic        error_header_early_termination,
    output logic [arp_pkg::drop_count_width-1:0] drop_count
);

    // header stage to decoder
    logic        eth_hdr_valid;
    logic        eth_hdr_ready;
    logic [47:0] eth_dest_mac;
    logic [47:0] eth_src_mac;
    logic [15:0] eth_type;
    logic [7:0]  pay_tdata;
    logic        pay_tvalid;
    logic        pay_tready;
    logic        pay_tlast;

    // decoder to checker
    logic        arp_valid;
    logic        arp_ready;
    logic [47:0] arp_eth_src_mac;
    logic [15:0] arp_htype;
    logic [15:0] arp_ptype;
    logic [7:0]  arp_hlen;
    logic [7:0]  arp_plen;
    logic [15:0] arp_oper;
    logic [47:0] arp_sha;
    logic [31:0] arp_spa;
    logic [47:0] arp_tha;
    logic [31:0] arp_tpa;

    eth_hdr_rx hdr0 (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tlast(s_tlast),
        .eth_hdr_valid(eth_hdr_valid), .eth_hdr_ready(eth_hdr_ready),
        .eth_dest_mac(eth_dest_mac), .eth_src_mac(eth_src_mac), .eth_type(eth_type),
        .pay_tdata(pay_tdata), .pay_tvalid(pay_tvalid), .pay_tready(pay_tready),
        .pay_tlast(pay_tlast)
    );

    arp_eth_rx dec0 (
        .clk(clk), .rst(rst),
        .eth_hdr_valid(eth_hdr_valid), .eth_hdr_ready(eth_hdr_ready),
        .eth_dest_mac(eth_dest_mac), .eth_src_mac(eth_src_mac), .eth_type(eth_type),
        .pay_tdata(pay_tdata), .pay_tvalid(pay_tvalid), .pay_tready(pay_tready),
        .pay_tlast(pay_tlast),
        .arp_valid(arp_valid), .arp_ready(arp_ready), .arp_eth_src_mac(arp_eth_src_mac),
        .arp_htype(arp_htype), .arp_ptype(arp_ptype), .arp_hlen(arp_hlen),
        .arp_plen(arp_plen), .arp_oper(arp_oper), .arp_sha(arp_sha), .arp_spa(arp_spa),
        .arp_tha(arp_tha), .arp_tpa(arp_tpa),
        .busy(busy), .error_header_early_termination(error_header_early_termination)
    );

    arp_req_check chk0 (
        .clk(clk), .rst(rst),
        .arp_valid(arp_valid), .arp_ready(arp_ready), .arp_eth_src_mac(arp_eth_src_mac),
        .arp_htype(arp_htype), .arp_ptype(arp_ptype), .arp_hlen(arp_hlen),
        .arp_plen(arp_plen), .arp_oper(arp_oper), .arp_sha(arp_sha), .arp_spa(arp_spa),
        .arp_tha(arp_tha), .arp_tpa(arp_tpa),
        .local_ip(local_ip),
        .m_valid(m_valid), .m_ready(m_ready), .m_oper(m_oper),
        .m_eth_src_mac(m_eth_src_mac), .m_sha(m_sha), .m_spa(m_spa), .m_tha(m_tha),
        .drop_count(drop_count)
    );

endmodule

// ==== verilog/arp_req_check.sv ====
//**********************************************************************
// ARP frame checker
// accepts Ethernet/IPv4 requests and replies aimed at the local IP,
// holds them in the output stage and counts the rejected frames
//**********************************************************************

`timescale 1ns/1ns

module arp_req_check (
    input  logic        clk,
    input  logic        rst,

    input  logic        arp_valid,
    output logic        arp_ready,
    input  logic [47:0] arp_eth_src_mac,
    input  logic [15:0] arp_htype,
    input  logic [15:0] arp_ptype,
    input  logic [7:0]  arp_hlen,
    input  logic [7:0]  arp_plen,
    input  logic [15:0] arp_oper,
    input  logic [47:0] arp_sha,
    input  logic [31:0] arp_spa,
    input  logic [47:0] arp_tha,
    input  logic [31:0] arp_tpa,

    input  logic [31:0] local_ip,

    output logic        m_valid,
    input  logic        m_ready,
    output logic [15:0] m_oper,
    output logic [47:0] m_eth_src_mac,
    output logic [47:0] m_sha,
    output logic [31:0] m_spa,
    output logic [47:0] m_tha,

    output logic [arp_pkg::drop_count_width-1:0] drop_count
);

    logic arp_fire;
    logic frame_ok;

    // the output stage is free or being emptied this cycle
    assign arp_ready = !m_valid || m_ready;
    assign arp_fire = arp_valid && arp_ready;

    assign frame_ok = (arp_htype == arp_pkg::arp_htype_eth) &&
                      (arp_ptype == arp_pkg::arp_ptype_ipv4) &&
                      (arp_hlen == arp_pkg::arp_hlen_eth) &&
                      (arp_plen == arp_pkg::arp_plen_ipv4) &&
                      ((arp_oper == arp_pkg::arp_oper_request) ||
                       (arp_oper == arp_pkg::arp_oper_reply)) &&
                      (arp_tpa == local_ip);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_valid <= 1'b0;
            drop_count <= '0;
        end else begin
            if (arp_fire && frame_ok) begin
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
            // saturate rather than wrap
            if (arp_fire && !frame_ok && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arp_fire && frame_ok) begin
            m_oper <= arp_oper;
            m_eth_src_mac <= arp_eth_src_mac;
            m_sha <= arp_sha;
            m_spa <= arp_spa;
            m_tha <= arp_tha;
        end
    end

endmodule

// ==== verilog/arp_eth_rx.sv ====
//**********************************************************************
// ARP frame decoder
// takes the Ethernet header and payload, decodes the 28-byte ARP
// body into fields, discards padding and frames of other types
//**********************************************************************

`timescale 1ns/1ns

module arp_eth_rx (
    input  logic        clk,
    input  logic        rst,

    input  logic        eth_hdr_valid,
    output logic        eth_hdr_ready,
    input  logic [47:0] eth_dest_mac,
    input  logic [47:0] eth_src_mac,
    input  logic [15:0] eth_type,

    input  logic [7:0]  pay_tdata,
    input  logic        pay_tvalid,
    output logic        pay_tready,
    input  logic        pay_tlast,

    output logic        arp_valid,
    input  logic        arp_ready,
    output logic [47:0] arp_eth_src_mac,
    output logic [15:0] arp_htype,
    output logic [15:0] arp_ptype,
    output logic [7:0]  arp_hlen,
    output logic [7:0]  arp_plen,
    output logic [15:0] arp_oper,
    output logic [47:0] arp_sha,
    output logic [31:0] arp_spa,
    output logic [47:0] arp_tha,
    output logic [31:0] arp_tpa,

    output logic        busy,
    output logic        error_header_early_termination
);

    typedef enum logic [1:0] {
        st_idle,
        st_read_header,
        st_wait_last,
        st_discard
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [4:0] frame_ptr;
    logic [4:0] frame_ptr_next;
    logic       hdr_fire;
    logic       pay_fire;
    logic       store_hdr;
    logic       store_byte;
    logic       arp_valid_next;
    logic       error_next;

    // ARP body, byte 0 sits in the top slot
    logic [arp_pkg::arp_body_len-1:0][7:0] arp_body;

    assign hdr_fire = eth_hdr_valid && eth_hdr_ready;
    assign pay_fire = pay_tvalid && pay_tready;

    // big-endian field layout in wire order; eth_dest_mac is not filtered here,
    // broadcast and unicast requests are both decoded
    assign {arp_htype, arp_ptype, arp_hlen, arp_plen, arp_oper,
            arp_sha, arp_spa, arp_tha, arp_tpa} = arp_body;

    always_comb begin
        state_next = state;
        frame_ptr_next = frame_ptr;
        store_hdr = 1'b0;
        store_byte = 1'b0;
        arp_valid_next = arp_valid && !arp_ready;
        error_next = 1'b0;

        case (state)
            st_idle: begin
                frame_ptr_next = '0;
                if (hdr_fire) begin
                    store_hdr = 1'b1;
                    if (eth_type == arp_pkg::ethertype_arp) begin
                        state_next = st_read_header;
                    end else begin
                        state_next = st_discard;
                    end
                end
            end
            st_read_header: begin
                if (pay_fire) begin
                    store_byte = 1'b1;
                    frame_ptr_next = frame_ptr + 5'd1;
                    if (frame_ptr == 5'(arp_pkg::arp_body_len - 1)) begin
                        arp_valid_next = 1'b1;
                        state_next = pay_tlast ? st_idle : st_wait_last;
                    end else if (pay_tlast) begin
                        // frame shorter than an ARP body
                        error_next = 1'b1;
                        state_next = st_idle;
                    end
                end
            end
            st_wait_last, st_discard: begin
                // padding or foreign payload, read and drop
                if (pay_fire && pay_tlast) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            frame_ptr <= '0;
            eth_hdr_ready <= 1'b0;
            pay_tready <= 1'b0;
            arp_valid <= 1'b0;
            error_header_early_termination <= 1'b0;
        end else begin
            state <= state_next;
            frame_ptr <= frame_ptr_next;
            arp_valid <= arp_valid_next;
            error_header_early_termination <= error_next;
            // a new header waits until the decoded frame has been taken
            eth_hdr_ready <= (state_next == st_idle) && !arp_valid_next;
            pay_tready <= (state_next != st_idle);
        end
    end

    // payload is accepted exactly while a frame is in progress
    assign busy = pay_tready;

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            arp_eth_src_mac <= eth_src_mac;
        end
        if (store_byte) begin
            arp_body[5'(arp_pkg::arp_body_len - 1) - frame_ptr] <= pay_tdata;
        end
    end

endmodule

// ==== verilog/eth_hdr_rx.sv ====
//**********************************************************************
// Ethernet header receiver
// collects the 14 header bytes into dest MAC, source MAC and
// Ethertype, then passes the payload bytes straight through
//**********************************************************************

`timescale 1ns/1ns

module eth_hdr_rx (
    input  logic        clk,
    input  logic        rst,

    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,

    output logic        eth_hdr_valid,
    input  logic        eth_hdr_ready,
    output logic [47:0] eth_dest_mac,
    output logic [47:0] eth_src_mac,
    output logic [15:0] eth_type,

    output logic [7:0]  pay_tdata,
    output logic        pay_tvalid,
    input  logic        pay_tready,
    output logic        pay_tlast
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } state_t;

    state_t     state;
    logic [3:0] hdr_cnt;
    logic       s_fire;
    logic       hdr_done;

    // header bytes are taken freely, payload follows downstream ready
    always_comb begin
        case (state)
            st_header:  s_tready = !eth_hdr_valid;
            st_payload: s_tready = pay_tready;
            default:    s_tready = 1'b0;
        endcase
    end

    assign s_fire = s_tvalid && s_tready;
    assign hdr_done = (hdr_cnt == 4'(arp_pkg::eth_hdr_len - 1));

    // payload pass-through
    assign pay_tdata = s_tdata;
    assign pay_tvalid = s_tvalid && (state == st_payload);
    assign pay_tlast = s_tlast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            hdr_cnt <= '0;
            eth_hdr_valid <= 1'b0;
        end else begin
            if (eth_hdr_valid && eth_hdr_ready) begin
                eth_hdr_valid <= 1'b0;
            end

            case (state)
                st_idle: begin
                    state <= st_header;
                end
                st_header: begin
                    if (s_fire) begin
                        if (s_tlast) begin
                            // runt frame, forget it and wait for the next one
                            hdr_cnt <= '0;
                        end else if (hdr_done) begin
                            hdr_cnt <= '0;
                            eth_hdr_valid <= 1'b1;
                            state <= st_payload;
                        end else begin
                            hdr_cnt <= hdr_cnt + 4'd1;
                        end
                    end
                end
                st_payload: begin
                    if (s_fire && s_tlast) begin
                        state <= st_header;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // header bytes arrive most significant first, so shift them in at the bottom
    always_ff @(posedge clk) begin
        if (state == st_header && s_fire) begin
            {eth_dest_mac, eth_src_mac, eth_type} <=
                {eth_dest_mac[39:0], eth_src_mac, eth_type, s_tdata};
        end
    end

endmodule

// ==== verilog/arp_pkg.sv ====
//**********************************************************************
// ARP receive constants
// frame lengths, Ethertype, ARP field values for Ethernet/IPv4
// and the width of the drop counter
//**********************************************************************

package arp_pkg;

    // Ethernet header, destination MAC + source MAC + Ethertype
    localparam int eth_hdr_len = 14;

    // ARP body for Ethernet/IPv4, padding that follows it is not counted
    localparam int arp_body_len = 28;

    localparam logic [15:0] ethertype_arp = 16'h0806;

    // hardware and protocol description fields
    localparam logic [15:0] arp_htype_eth = 16'h0001;
    localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;
    localparam logic [7:0] arp_hlen_eth = 8'd6;
    localparam logic [7:0] arp_plen_ipv4 = 8'd4;

    // operation codes
    localparam logic [15:0] arp_oper_request = 16'h0001;
    localparam logic [15:0] arp_oper_reply = 16'h0002;

    // saturating counter of frames rejected by the checker
    localparam int drop_count_width = 16;

endpackage
